// File: rtl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ****************************************
// data path widths
// ****************************************
`define XLEN      32
`define REG_AW    5
`define NUM_REGS  32

// ****************************************
// rv32i base opcodes
// ****************************************
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_SYSTEM 7'b1110011
`define OP_FENCE  7'b0001111

// arithmetic and logic funct3
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SR      3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// sub / sra marker in funct7
`define F7_ALT 7'b0100000

`endif

// File: rtl/rv_data_pkg.sv
`include "core_consts.svh"

package rv_data_pkg;

    // one data word
    typedef logic [`XLEN-1:0] word_t;

    // register index
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // program counter
    typedef logic [`XLEN-1:0] pc_t;

    // instruction subfield
    typedef logic [2:0] funct3_t;

endpackage

// File: rtl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_eq,
        alu_neq,
        alu_lt,
        alu_ltu,
        alu_ge,
        alu_geu
    } alu_op_e;

    typedef enum logic [3:0] {
        cls_rtype,
        cls_itype,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui,
        cls_auipc,
        cls_system,
        cls_fence,
        cls_bad
    } instr_class_e;

    typedef enum logic [1:0] {
        exc_none,
        exc_illegal_opcode,
        exc_illegal_shift,
        exc_env_call
    } exc_e;

endpackage

// File: rtl/decode_if.sv
interface decode_if
    import rv_data_pkg::*;
    import rv_ctrl_pkg::*;
();

    logic         ce;
    pc_t          pc;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        imm;
    funct3_t      funct3;
    alu_op_e      alu_op;
    instr_class_e iclass;
    exc_e         exc;
    logic         writes_rd;

    // decoder side
    modport producer (
        output ce, pc, rs1, rs2, rd, imm, funct3,
        output alu_op, iclass, exc, writes_rd
    );

    // execute side
    modport consumer (
        input ce, pc, rs1, rs2, rd, imm, funct3,
        input alu_op, iclass, exc, writes_rd
    );

endinterface

// File: rtl/decoder.sv
`include "core_consts.svh"

module decoder
    import rv_data_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic       d_clk,
    input  logic       d_rst,
    input  word_t      instr,
    input  pc_t        pc,
    input  logic       in_ce,
    input  logic       stall,
    input  logic       flush,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    decode_if.producer dec
);

    logic [6:0]   opcode;
    logic [6:0]   funct7;
    funct3_t      funct3;
    reg_addr_t    rd_addr;
    logic         f7_alt;
    logic         f7_bad;
    logic         accept;
    instr_class_e iclass_d;
    word_t        imm_d;
    alu_op_e      alu_op_d;
    exc_e         exc_d;
    logic         writes_rd_d;

    // register addresses go straight to the register file
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];

    assign f7_alt = (funct7 & `F7_ALT) != 7'd0;
    assign f7_bad = (funct7 & ~`F7_ALT) != 7'd0;
    assign accept = in_ce && !stall && !flush;

    // ****************************************
    // classify
    // ****************************************
    always_comb begin
        case (opcode)
            `OP_RTYPE:  iclass_d = cls_rtype;
            `OP_ITYPE:  iclass_d = cls_itype;
            `OP_LOAD:   iclass_d = cls_load;
            `OP_STORE:  iclass_d = cls_store;
            `OP_BRANCH: iclass_d = cls_branch;
            `OP_JAL:    iclass_d = cls_jal;
            `OP_JALR:   iclass_d = cls_jalr;
            `OP_LUI:    iclass_d = cls_lui;
            `OP_AUIPC:  iclass_d = cls_auipc;
            `OP_SYSTEM: iclass_d = cls_system;
            `OP_FENCE:  iclass_d = cls_fence;
            default:    iclass_d = cls_bad;
        endcase
    end

    // immediate per format, i-type by default
    always_comb begin
        case (iclass_d)
            cls_store:  imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cls_branch: imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            cls_jal:    imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            cls_lui,
            cls_auipc:  imm_d = {instr[31:12], 12'd0};
            default:    imm_d = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        alu_op_d = alu_add;
        if (iclass_d == cls_rtype || iclass_d == cls_itype) begin
            case (funct3)
                `F3_ADD_SUB: alu_op_d = (iclass_d == cls_rtype && f7_alt) ? alu_sub : alu_add;
                `F3_SLL:     alu_op_d = alu_sll;
                `F3_SLT:     alu_op_d = alu_slt;
                `F3_SLTU:    alu_op_d = alu_sltu;
                `F3_XOR:     alu_op_d = alu_xor;
                `F3_SR:      alu_op_d = f7_alt ? alu_sra : alu_srl;
                `F3_OR:      alu_op_d = alu_or;
                `F3_AND:     alu_op_d = alu_and;
                default:     alu_op_d = alu_add;
            endcase
        end else if (iclass_d == cls_branch) begin
            case (funct3)
                `F3_BEQ:  alu_op_d = alu_eq;
                `F3_BNE:  alu_op_d = alu_neq;
                `F3_BLT:  alu_op_d = alu_lt;
                `F3_BGE:  alu_op_d = alu_ge;
                `F3_BLTU: alu_op_d = alu_ltu;
                `F3_BGEU: alu_op_d = alu_geu;
                default:  alu_op_d = alu_eq;
            endcase
        end
    end

    // ****************************************
    // exceptions
    // ****************************************
    always_comb begin
        exc_d = exc_none;
        if (iclass_d == cls_bad) begin
            exc_d = exc_illegal_opcode;
        end else if (iclass_d == cls_system) begin
            exc_d = exc_env_call;
        end else if (iclass_d == cls_itype && f7_bad &&
                     (funct3 == `F3_SLL || funct3 == `F3_SR)) begin
            exc_d = exc_illegal_shift;
        end
    end

    assign writes_rd_d = (exc_d == exc_none) && (rd_addr != '0) &&
                         (iclass_d != cls_store) && (iclass_d != cls_branch) &&
                         (iclass_d != cls_fence);

    // flush drops whatever is presented this cycle
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            dec.ce <= 1'b0;
        end else if (!stall) begin
            dec.ce <= in_ce && !flush;
        end
    end

    always_ff @(posedge d_clk) begin
        if (accept) begin
            dec.pc        <= pc;
            dec.rs1       <= rs1_addr;
            dec.rs2       <= rs2_addr;
            dec.rd        <= rd_addr;
            dec.imm       <= imm_d;
            dec.funct3    <= funct3;
            dec.alu_op    <= alu_op_d;
            dec.iclass    <= iclass_d;
            dec.exc       <= exc_d;
            dec.writes_rd <= writes_rd_d;
        end
    end

    a_bad_has_exc: assert property (@(posedge d_clk) disable iff (!d_rst)
        (dec.ce && dec.exc == exc_none) |-> dec.iclass != cls_bad)
        else $error("unknown opcode left decode without an exception");

endmodule

// File: rtl/reg_file.sv
`include "core_consts.svh"

module reg_file
    import rv_data_pkg::*;
(
    input  logic      d_clk,
    input  logic      d_rst,
    input  logic      rd_en,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`NUM_REGS];

    // read returns the value before a write on the same edge
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            if (wr_en && wr_addr != '0) begin
                regs[wr_addr] <= wr_data;
            end
            if (rd_en) begin
                rs1_data <= (rs1_addr == '0) ? '0 : regs[rs1_addr];
                rs2_data <= (rs2_addr == '0) ? '0 : regs[rs2_addr];
            end
        end
    end

    // x0 writes are filtered in decode
    a_no_x0_write: assert property (@(posedge d_clk) disable iff (!d_rst)
        wr_en |-> wr_addr != '0)
        else $error("write enabled to x0");

endmodule

// File: rtl/alu_execute.sv
module alu_execute
    import rv_data_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic       d_clk,
    input  logic       d_rst,
    input  logic       stall,
    decode_if.consumer dec,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output logic       wr_en,
    output reg_addr_t  wr_addr,
    output word_t      wr_data,
    output logic       out_ce,
    output pc_t        out_pc,
    output word_t      result,
    output reg_addr_t  rd,
    output logic       branch_taken,
    output pc_t        target,
    output exc_e       exc
);

    logic       fwd_vld;
    word_t      op_a;
    word_t      src2;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_out;
    word_t      res_d;
    pc_t        target_d;
    logic       taken_d;

    // ****************************************
    // operand select
    // ****************************************
    // previous write landed on the same edge as our read
    assign op_a = (fwd_vld && rd == dec.rs1) ? result : rs1_data;
    assign src2 = (fwd_vld && rd == dec.rs2) ? result : rs2_data;
    assign op_b = (dec.iclass == cls_rtype || dec.iclass == cls_branch) ? src2 : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_out = word_t'(op_a < op_b);
            alu_xor:  alu_out = op_a ^ op_b;
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = word_t'($signed(op_a) >>> shamt);
            alu_eq:   alu_out = word_t'(op_a == op_b);
            alu_neq:  alu_out = word_t'(op_a != op_b);
            alu_lt:   alu_out = word_t'($signed(op_a) < $signed(op_b));
            alu_ltu:  alu_out = word_t'(op_a < op_b);
            alu_ge:   alu_out = word_t'($signed(op_a) >= $signed(op_b));
            alu_geu:  alu_out = word_t'(op_a >= op_b);
            default:  alu_out = '0;
        endcase
    end

    // ****************************************
    // result and target
    // ****************************************
    always_comb begin
        res_d    = alu_out;
        target_d = dec.pc + dec.imm;
        case (dec.iclass)
            cls_lui:   res_d = dec.imm;
            cls_auipc: res_d = dec.pc + dec.imm;
            cls_jal:   res_d = dec.pc + 32'd4;
            cls_jalr: begin
                res_d    = dec.pc + 32'd4;
                target_d = (op_a + dec.imm) & ~32'd1;
            end
            cls_system,
            cls_fence,
            cls_bad:   res_d = '0;
            default:   res_d = alu_out;
        endcase
    end

    // funct3 010 and 011 are not branches
    assign taken_d = (dec.iclass == cls_branch) && alu_out[0] && (dec.funct3[2:1] != 2'b01);

    assign wr_en   = dec.ce && dec.writes_rd && !stall;
    assign wr_addr = dec.rd;
    assign wr_data = res_d;

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            out_ce       <= 1'b0;
            branch_taken <= 1'b0;
            fwd_vld      <= 1'b0;
        end else if (!stall) begin
            out_ce       <= dec.ce;
            branch_taken <= dec.ce && taken_d;
            fwd_vld      <= wr_en;
        end
    end

    always_ff @(posedge d_clk) begin
        if (dec.ce && !stall) begin
            out_pc <= dec.pc;
            result <= res_d;
            rd     <= dec.rd;
            target <= target_d;
            exc    <= dec.exc;
        end
    end

    a_ce_after_reset: assert property (@(posedge d_clk)
        $rose(d_rst) |-> !out_ce)
        else $error("out_ce high right after reset");

    a_wr_no_exc: assert property (@(posedge d_clk) disable iff (!d_rst)
        wr_en |-> dec.exc == exc_none)
        else $error("register write for an excepting instruction");

endmodule

// File: rtl/rv_core_top.sv
module rv_core_top
    import rv_data_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic      d_clk,
    input  logic      d_rst,
    input  word_t     instr,
    input  pc_t       pc,
    input  logic      in_ce,
    input  logic      stall,
    input  logic      flush,
    output logic      out_ce,
    output pc_t       out_pc,
    output word_t     result,
    output reg_addr_t rd,
    output logic      branch_taken,
    output pc_t       target,
    output exc_e      exc
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    decode_if dec_bus ();

    decoder u_decoder (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .instr    (instr),
        .pc       (pc),
        .in_ce    (in_ce),
        .stall    (stall),
        .flush    (flush),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .dec      (dec_bus.producer)
    );

    // read data registers alongside the decoder outputs
    reg_file u_reg_file (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .rd_en    (!stall),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    alu_execute u_alu_execute (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .stall        (stall),
        .dec          (dec_bus.consumer),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .out_ce       (out_ce),
        .out_pc       (out_pc),
        .result       (result),
        .rd           (rd),
        .branch_taken (branch_taken),
        .target       (target),
        .exc          (exc)
    );

endmodule

// File: dv/tb_rv_core.sv
`include "core_consts.svh"

module tb_rv_core
    import rv_data_pkg::*;
    import rv_ctrl_pkg::*;
();

    localparam int N_INIT  = 62;
    localparam int N_ARITH = 200;
    localparam int N_EXC   = 16;
    localparam int N_CTRL  = 60;
    localparam int N_CHAIN = 40;
    localparam int N_STALL = 150;
    localparam int N_FLUSH = 40;
    localparam int N_TOTAL = N_INIT + N_ARITH + N_EXC + N_CTRL + N_CHAIN + N_STALL + N_FLUSH;
    localparam int LIMIT   = 2 * N_TOTAL + 200;

    localparam int MODE_ARITH = 0;
    localparam int MODE_EXC   = 1;
    localparam int MODE_CTRL  = 2;
    localparam int MODE_CHAIN = 3;
    localparam int MODE_MIX   = 4;

    typedef struct packed {
        pc_t         pc;
        word_t       res;
        reg_addr_t   rdx;
        logic        taken;
        pc_t         tgt;
        exc_e        exc;
        logic        wr;
        logic        chk_res;
        logic        chk_tgt;
        logic [31:0] acc;
    } exp_t;

    logic        d_clk = 1'b0;
    logic        d_rst;
    word_t       instr;
    pc_t         pc;
    logic        in_ce;
    logic        stall;
    logic        flush;
    logic        out_ce;
    pc_t         out_pc;
    word_t       result;
    reg_addr_t   rd;
    logic        branch_taken;
    pc_t         target;
    exc_e        exc;

    word_t       shadow [32];
    exp_t        exp_q [$];
    word_t       seed = 32'h72927668;
    pc_t         next_pc;
    reg_addr_t   hist [2];
    logic [31:0] edge_cnt = 0;
    logic [31:0] cycles = 0;
    logic        upd = 1'b0;
    logic        held = 1'b0;
    int          mismatches = 0;
    int          others = 0;

    logic        snap_ce;
    pc_t         snap_pc;
    word_t       snap_res;
    reg_addr_t   snap_rd;
    logic        snap_taken;
    pc_t         snap_tgt;
    exc_e        snap_exc;

    always #10 d_clk = ~d_clk;

    rv_core_top u_rv_core_top (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .instr        (instr),
        .pc           (pc),
        .in_ce        (in_ce),
        .stall        (stall),
        .flush        (flush),
        .out_ce       (out_ce),
        .out_pc       (out_pc),
        .result       (result),
        .rd           (rd),
        .branch_taken (branch_taken),
        .target       (target),
        .exc          (exc)
    );

    // ****************************************
    // reference model
    // ****************************************
    function automatic word_t next_random();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic word_t alu_ref(input funct3_t f3, input logic alt, input word_t a,
                                      input word_t b);
        logic signed [31:0] sa;
        sa = $signed(a);
        case (f3)
            `F3_ADD_SUB: return alt ? a - b : a + b;
            `F3_SLL:     return a << b[4:0];
            `F3_SLT:     return {31'd0, $signed(a) < $signed(b)};
            `F3_SLTU:    return {31'd0, a < b};
            `F3_XOR:     return a ^ b;
            `F3_SR: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            `F3_OR:      return a | b;
            default:     return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            `F3_BEQ:  return a == b;
            `F3_BNE:  return a != b;
            `F3_BLT:  return $signed(a) < $signed(b);
            `F3_BGE:  return $signed(a) >= $signed(b);
            `F3_BLTU: return a < b;
            `F3_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic exp_t ref_model(input word_t ins, input pc_t ipc);
        exp_t       e;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      imm_u;
        funct3_t    f3;
        logic [6:0] f7;
        a = shadow[ins[19:15]];
        b = shadow[ins[24:20]];
        f3 = ins[14:12];
        f7 = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'd0};
        e = '0;
        e.pc = ipc;
        e.rdx = ins[11:7];
        e.exc = exc_none;
        case (ins[6:0])
            `OP_RTYPE:  e.res = alu_ref(f3, f7[5], a, b);
            `OP_ITYPE: begin
                e.res = alu_ref(f3, f3 == `F3_SR && f7[5], a, imm_i);
                if ((f3 == `F3_SLL || f3 == `F3_SR) && (f7 & ~`F7_ALT) != 7'd0) begin
                    e.exc = exc_illegal_shift;
                end
            end
            `OP_LOAD:   e.res = a + imm_i;
            `OP_STORE:  e.res = a + imm_s;
            `OP_LUI:    e.res = imm_u;
            `OP_AUIPC:  e.res = ipc + imm_u;
            `OP_JAL: begin
                e.res = ipc + 32'd4;
                e.tgt = ipc + imm_j;
                e.chk_tgt = 1'b1;
            end
            `OP_JALR: begin
                e.res = ipc + 32'd4;
                e.tgt = (a + imm_i) & ~32'd1;
                e.chk_tgt = 1'b1;
            end
            `OP_BRANCH: begin
                e.taken = branch_ref(f3, a, b);
                e.tgt = ipc + imm_b;
                e.chk_tgt = 1'b1;
            end
            `OP_SYSTEM: e.exc = exc_env_call;
            `OP_FENCE:  e.res = '0;
            default:    e.exc = exc_illegal_opcode;
        endcase
        e.chk_res = e.exc == exc_none && ins[6:0] != `OP_BRANCH;
        e.wr = e.exc == exc_none && e.rdx != 5'd0 && ins[6:0] != `OP_STORE &&
               ins[6:0] != `OP_BRANCH && ins[6:0] != `OP_FENCE;
        return e;
    endfunction

    // ****************************************
    // stimulus
    // ****************************************
    function automatic word_t gen_instr(input int mode);
        word_t   w;
        word_t   sel;
        funct3_t f3;
        funct3_t bf3;
        logic    pick;
        w = next_random();
        sel = next_random();
        f3 = w[14:12];
        // only the six defined branch codes
        bf3 = sel[5] ? sel[5:3] : {2'b00, sel[3]};
        case (mode)
            MODE_EXC: begin
                case (sel[1:0])
                    2'd0: w = {w[31:25] | 7'b0000001, w[24:15],
                               sel[2] ? `F3_SLL : `F3_SR, w[11:7], `OP_ITYPE};
                    2'd1: w = {w[31:7], sel[2] ? 7'b1111111 : 7'b0001011};
                    2'd2: w = {w[31:7], `OP_SYSTEM};
                    default: w = {w[31:7], `OP_FENCE};
                endcase
            end
            MODE_CTRL: begin
                case (sel[2:0])
                    3'd0: w = {w[31:7], `OP_LUI};
                    3'd1: w = {w[31:7], `OP_AUIPC};
                    3'd2: w = {w[31:7], `OP_JAL};
                    3'd3: w = {w[31:15], 3'b000, w[11:7], `OP_JALR};
                    3'd4: w = {w[31:15], bf3, w[11:7], `OP_BRANCH};
                    // equal operands
                    3'd5: w = {w[31:25], w[19:15], w[19:15], bf3, w[11:7], `OP_BRANCH};
                    3'd6: w = {w[31:7], `OP_LOAD};
                    default: w = {w[31:15], 3'b010, w[11:7], `OP_STORE};
                endcase
            end
            default: begin
                if (sel[0]) begin
                    w = {((f3 == `F3_ADD_SUB || f3 == `F3_SR) && sel[1]) ? `F7_ALT : 7'd0,
                         w[24:7], `OP_RTYPE};
                end else if (f3 == `F3_SLL) begin
                    w = {7'd0, w[24:7], `OP_ITYPE};
                end else if (f3 == `F3_SR) begin
                    w = {sel[1] ? `F7_ALT : 7'd0, w[24:7], `OP_ITYPE};
                end else begin
                    w = {w[31:7], `OP_ITYPE};
                end
                // sources from the last two destinations
                if (mode == MODE_CHAIN) begin
                    pick = sel[2];
                    w[19:15] = hist[pick];
                    if (sel[0]) begin
                        w[24:20] = hist[!pick];
                    end
                    if (sel[5:3] == 3'd0) begin
                        w[11:7] = 5'd0;
                    end
                    hist[1] = hist[0];
                    hist[0] = w[11:7];
                end
            end
        endcase
        return w;
    endfunction

    task automatic issue(input word_t ins, input logic stall_en, input logic drop);
        logic st;
        st = 1'b1;
        while (st) begin
            st = stall_en && (next_random() & 32'd3) == 32'd0;
            @(posedge d_clk);
            instr <= ins;
            pc    <= next_pc;
            in_ce <= 1'b1;
            stall <= st;
            flush <= drop && !st;
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge d_clk);
            in_ce <= 1'b0;
            stall <= 1'b0;
            flush <= 1'b0;
        end
    endtask

    task automatic run_phase(input int n, input int mode, input logic stall_en,
                             input logic flush_en);
        int    m;
        word_t r;
        for (int i = 0; i < n; i++) begin
            r = next_random();
            m = (mode == MODE_MIX) ? int'(r[1:0]) : mode;
            issue(gen_instr(m), stall_en, flush_en && r[4:2] == 3'd0);
        end
        idle(3);
    endtask

    // ****************************************
    // checking
    // ****************************************
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, want);
        end
    endtask

    // accepted instructions update the shadow state in order
    always @(posedge d_clk) begin : monitor
        exp_t e;
        upd  = d_rst && !stall;
        held = d_rst && stall;
        if (upd) begin
            edge_cnt = edge_cnt + 1;
        end
        if (d_rst && in_ce && !stall && !flush) begin
            e = ref_model(instr, pc);
            e.acc = edge_cnt;
            if (e.wr) begin
                shadow[e.rdx] = e.res;
            end
            exp_q.push_back(e);
        end
    end

    always @(negedge d_clk) begin : compare
        exp_t e;
        if (held) begin
            check("out_ce (held)", out_ce, snap_ce);
            check("out_pc (held)", out_pc, snap_pc);
            check("result (held)", result, snap_res);
            check("rd (held)", rd, snap_rd);
            check("branch_taken (held)", branch_taken, snap_taken);
            check("target (held)", target, snap_tgt);
            check("exc (held)", exc, snap_exc);
        end
        if (upd && out_ce) begin
            if (exp_q.size() == 0) begin
                others++;
                $display("out_ce went high with no accepted instruction pending, pc %h", out_pc);
            end else begin
                e = exp_q.pop_front();
                check("out_pc", out_pc, e.pc);
                check("rd", rd, e.rdx);
                check("exc", exc, e.exc);
                check("branch_taken", branch_taken, e.taken);
                if (e.chk_res) begin
                    check("result", result, e.res);
                end
                if (e.chk_tgt) begin
                    check("target", target, e.tgt);
                end
                // acceptance edge counts as the first
                check("out_ce latency", edge_cnt - e.acc + 1, 32'd2);
            end
        end
        snap_ce    = out_ce;
        snap_pc    = out_pc;
        snap_res   = result;
        snap_rd    = rd;
        snap_taken = branch_taken;
        snap_tgt   = target;
        snap_exc   = exc;
    end

    always @(posedge d_clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("errors: %0d value mismatches, %0d other", mismatches, others);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        word_t     v;
        reg_addr_t ra;
        d_rst = 1'b0;
        instr = '0;
        pc    = '0;
        in_ce = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        next_pc = 32'h0000_1000;
        hist[0] = 5'd1;
        hist[1] = 5'd2;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge d_clk);
        d_rst <= 1'b1;

        // lui then addi on the same register
        for (int r = 1; r < 32; r++) begin
            v = next_random();
            ra = r[4:0];
            issue({v[31:12], ra, `OP_LUI}, 1'b0, 1'b0);
            issue({v[11:0], ra, `F3_ADD_SUB, ra, `OP_ITYPE}, 1'b0, 1'b0);
        end
        run_phase(N_ARITH, MODE_ARITH, 1'b0, 1'b0);
        run_phase(N_EXC, MODE_EXC, 1'b0, 1'b0);
        run_phase(N_CTRL, MODE_CTRL, 1'b0, 1'b0);
        run_phase(N_CHAIN, MODE_CHAIN, 1'b0, 1'b0);
        run_phase(N_STALL, MODE_MIX, 1'b1, 1'b0);
        run_phase(N_FLUSH, MODE_MIX, 1'b0, 1'b1);

        for (int i = 0; i < 20 && exp_q.size() != 0; i++) begin
            @(posedge d_clk);
        end
        if (exp_q.size() != 0) begin
            others++;
            $display("%0d accepted instructions never reached out_ce", exp_q.size());
        end
        $display("errors: %0d value mismatches, %0d other", mismatches, others);
        if (mismatches == 0 && others == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/rv_data_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/decode_if.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu_execute.sv
rtl/rv_core_top.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_data_pkg.sv
      - rtl/rv_ctrl_pkg.sv
      - rtl/decode_if.sv
      - rtl/decoder.sv
      - rtl/reg_file.sv
      - rtl/alu_execute.sv
      - rtl/rv_core_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_rv_core.sv
